// File: Makefile
# verilator build and run of the simd alu testbench
TOP = tb_simd_alu

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f compile.f

run: compile
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	grep -qx "TB PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// File: compile.f
+incdir+sim
hw/simd_alu_pkg.sv
hw/lane_addsub.sv
hw/lane_mult.sv
hw/lane_shift.sv
hw/vector_alu.sv
hw/wb_alu_ctrl.sv
hw/simd_alu_top.sv
sim/tb_simd_alu.sv

// File: hw/lane_addsub.sv
/* packed add/subtract built from eight byte slices
   carries cross a byte boundary only inside one element of the selected width */
`timescale 1ns/1ns

module lane_addsub (
	input  logic [0:simd_alu_pkg::data_w-1] op_a,
	input  logic [0:simd_alu_pkg::data_w-1] op_b,
	input  logic                            sub,
	input  simd_alu_pkg::elem_width_e       width,
	output logic [0:simd_alu_pkg::data_w-1] sum
);

	// link[s] joins slice s to the less significant slice s+1
	logic [0:6] link;

	always_comb begin
		for (int s = 0; s < 7; s++) begin
			case (width)
				simd_alu_pkg::w8:  link[s] = 1'b0;
				// byte pairs
				simd_alu_pkg::w16: link[s] = (s % 2 == 0);
				// break every fourth byte
				simd_alu_pkg::w32: link[s] = (s % 4 != 3);
				default:           link[s] = 1'b1;
			endcase
		end
	end

	// slice 0 is the top byte, slice 7 the bottom
	for (genvar g = 0; g < 8; g++) begin : g_slice
		logic [0:7] b_eff;
		logic       ci;
		logic [8:0] wide;

		// a - b as a + ~b + 1
		assign b_eff = op_b[g*8 +: 8] ^ {8{sub}};

		if (g == 7) begin : g_lsb
			assign ci = sub;
		end else begin : g_upper
			// lowest byte of an element takes the +1 for subtract
			assign ci = link[g] ? g_slice[g+1].wide[8] : sub;
		end

		assign wide = {1'b0, op_a[g*8 +: 8]} + {1'b0, b_eff} + {8'd0, ci};
		// carry out of the element's top byte is dropped
		assign sum[g*8 +: 8] = wide[7:0];
	end

endmodule

// File: hw/lane_mult.sv
/* unsigned multiply or square of the even or odd elements, double width product
   four 8x8, two 16x16 and one 32x32 multiplier; 64-bit elements give zero */
`timescale 1ns/1ns

module lane_mult (
	input  logic [0:simd_alu_pkg::data_w-1] op_a,
	input  logic [0:simd_alu_pkg::data_w-1] op_b,
	input  simd_alu_pkg::alu_op_e           op,
	input  simd_alu_pkg::elem_width_e       width,
	output logic [0:simd_alu_pkg::data_w-1] product
);

	// odd picks elements 1, 3, ...
	logic                            odd;
	// square multiplies a by itself
	logic                            square;
	logic [0:simd_alu_pkg::data_w-1] fb;

	// products in element order, element 0 on top
	logic [0:3][0:15] p8;
	logic [0:1][0:31] p16;
	logic [0:63]      p32;

	assign odd    = (op == simd_alu_pkg::op_mul_odd) || (op == simd_alu_pkg::op_sq_odd);
	assign square = (op == simd_alu_pkg::op_sq_even) || (op == simd_alu_pkg::op_sq_odd);
	assign fb     = square ? op_a : op_b;

	// byte elements 2k or 2k+1
	for (genvar k = 0; k < 4; k++) begin : g_m8
		logic [0:7] fa_e;
		logic [0:7] fb_e;

		assign fa_e  = op_a[(2*k + odd)*8 +: 8];
		assign fb_e  = fb[(2*k + odd)*8 +: 8];
		assign p8[k] = {8'd0, fa_e} * {8'd0, fb_e};
	end

	// halfword elements 2k or 2k+1
	for (genvar k = 0; k < 2; k++) begin : g_m16
		logic [0:15] fa_e;
		logic [0:15] fb_e;

		assign fa_e   = op_a[(2*k + odd)*16 +: 16];
		assign fb_e   = fb[(2*k + odd)*16 +: 16];
		assign p16[k] = {16'd0, fa_e} * {16'd0, fb_e};
	end

	// word element 0 or 1
	logic [0:31] fa32;
	logic [0:31] fb32;

	assign fa32 = op_a[odd*32 +: 32];
	assign fb32 = fb[odd*32 +: 32];
	assign p32  = {32'd0, fa32} * {32'd0, fb32};

	always_comb begin
		case (width)
			simd_alu_pkg::w8:  product = p8;
			simd_alu_pkg::w16: product = p16;
			simd_alu_pkg::w32: product = p32;
			// no 64x64 multiplier
			default:           product = '0;
		endcase
	end

endmodule

// File: hw/lane_shift.sv
/* per-element shifts and half swap at all four element widths
   each element is shifted by the low bits of the matching element of b */
`timescale 1ns/1ns

module lane_shift (
	input  logic [0:simd_alu_pkg::data_w-1] op_a,
	input  logic [0:simd_alu_pkg::data_w-1] op_b,
	input  simd_alu_pkg::alu_op_e           op,
	input  simd_alu_pkg::elem_width_e       width,
	output logic [0:simd_alu_pkg::data_w-1] shifted
);

	// one full result per element width, indexed by the width code
	logic [0:3][0:simd_alu_pkg::data_w-1] res_w;

	// wi picks 8, 16, 32 or 64 bit elements
	for (genvar wi = 0; wi < 4; wi++) begin : g_w
		for (genvar e = 0; e < simd_alu_pkg::data_w / (8 << wi); e++) begin : g_e
			logic [0:(8 << wi)-1] a_e;
			// log2 of element bits
			logic [0:2+wi]        amt;
			logic [0:(8 << wi)-1] r;

			assign a_e = op_a[e*(8 << wi) +: (8 << wi)];
			// low bits sit at the right end of the element
			assign amt = op_b[e*(8 << wi) + (8 << wi) - (3 + wi) +: (3 + wi)];

			always_comb begin
				case (op)
					simd_alu_pkg::op_sll: r = a_e << amt;
					simd_alu_pkg::op_srl: r = a_e >> amt;
					// fill with the element sign bit
					simd_alu_pkg::op_sra: r = $signed(a_e) >>> amt;
					// lower half moves up, b not used
					simd_alu_pkg::op_rot_half:
						r = {a_e[(4 << wi) +: (4 << wi)], a_e[0 +: (4 << wi)]};
					default: r = '0;
				endcase
			end

			assign res_w[wi][e*(8 << wi) +: (8 << wi)] = r;
		end
	end

	assign shifted = res_w[width];

endmodule

// File: hw/simd_alu_pkg.sv
/* widths, opcodes, register map and bus structs shared by the simd alu rtl
   every file refers to these by scoped name */
package simd_alu_pkg;

	// operand, result and bus data width
	localparam int data_w = 64;
	// word address into the four 64-bit registers
	localparam int adr_w = 2;

	// alu opcodes
	// 14, 15 and 18 are unused codes
	typedef enum logic [5:0] {
		op_nop      = 6'd0,
		op_and      = 6'd1,
		op_or       = 6'd2,
		op_xor      = 6'd3,
		op_not      = 6'd4,
		op_mov      = 6'd5,
		op_add      = 6'd6,
		op_sub      = 6'd7,
		op_mul_even = 6'd8,
		op_mul_odd  = 6'd9,
		op_sll      = 6'd10,
		op_srl      = 6'd11,
		op_sra      = 6'd12,
		op_rot_half = 6'd13,
		op_sq_even  = 6'd16,
		op_sq_odd   = 6'd17
	} alu_op_e;

	// element size inside a 64-bit operand
	typedef enum logic [1:0] {
		w8  = 2'd0,
		w16 = 2'd1,
		w32 = 2'd2,
		w64 = 2'd3
	} elem_width_e;

	// low byte of the command register, opcode on top
	typedef struct packed {
		alu_op_e     op;
		elem_width_e width;
	} alu_cmd_t;

	// register map, word addressed
	typedef enum logic [1:0] {
		reg_a      = 2'd0,
		reg_b      = 2'd1,
		reg_cmd    = 2'd2,
		reg_result = 2'd3
	} reg_addr_e;

	// wishbone classic, master to slave
	typedef struct packed {
		logic              cyc;
		logic              stb;
		logic              we;
		logic [adr_w-1:0]  adr;
		logic [0:data_w-1] dat_w;
	} wb_req_t;

	// wishbone classic, slave to master
	typedef struct packed {
		logic              ack;
		logic [0:data_w-1] dat_r;
	} wb_rsp_t;

	// bus slave fsm
	typedef enum logic {
		st_idle = 1'b0,
		st_ack  = 1'b1
	} ctrl_state_e;

endpackage

// File: hw/simd_alu_top.sv
/* simd alu top, wishbone register block feeding the combinational datapath
   the bus master sees four 64-bit registers: a, b, command, result */
`timescale 1ns/1ns

module simd_alu_top (
	input  logic                  clk,
	input  logic                  reset,
	input  simd_alu_pkg::wb_req_t wb_req,
	output simd_alu_pkg::wb_rsp_t wb_rsp
);

	// registered operands and command
	logic [0:simd_alu_pkg::data_w-1] op_a;
	logic [0:simd_alu_pkg::data_w-1] op_b;
	simd_alu_pkg::alu_cmd_t          cmd;
	// combinational datapath output
	logic [0:simd_alu_pkg::data_w-1] alu_result;

	// bus slave and registers
	wb_alu_ctrl u_ctrl (
		.clk        (clk),
		.reset      (reset),
		.wb_req     (wb_req),
		.wb_rsp     (wb_rsp),
		.op_a       (op_a),
		.op_b       (op_b),
		.cmd        (cmd),
		.alu_result (alu_result)
	);

	// zero latency datapath
	vector_alu u_alu (
		.op_a   (op_a),
		.op_b   (op_b),
		.cmd    (cmd),
		.result (alu_result)
	);

endmodule

// File: hw/vector_alu.sv
/* combinational simd alu, logic ops done here, arithmetic in the lane units
   result is picked by opcode, unknown opcodes give zero */
`timescale 1ns/1ns

module vector_alu (
	input  logic [0:simd_alu_pkg::data_w-1] op_a,
	input  logic [0:simd_alu_pkg::data_w-1] op_b,
	input  simd_alu_pkg::alu_cmd_t          cmd,
	output logic [0:simd_alu_pkg::data_w-1] result
);

	logic [0:simd_alu_pkg::data_w-1] logic_res;
	logic [0:simd_alu_pkg::data_w-1] sum;
	logic [0:simd_alu_pkg::data_w-1] product;
	logic [0:simd_alu_pkg::data_w-1] shifted;
	logic                            sub;

	// only sub inverts b
	assign sub = (cmd.op == simd_alu_pkg::op_sub);

	lane_addsub u_addsub (
		.op_a  (op_a),
		.op_b  (op_b),
		.sub   (sub),
		.width (cmd.width),
		.sum   (sum)
	);

	lane_mult u_mult (
		.op_a    (op_a),
		.op_b    (op_b),
		.op      (cmd.op),
		.width   (cmd.width),
		.product (product)
	);

	lane_shift u_shift (
		.op_a    (op_a),
		.op_b    (op_b),
		.op      (cmd.op),
		.width   (cmd.width),
		.shifted (shifted)
	);

	// bitwise ops, width plays no part
	always_comb begin
		case (cmd.op)
			simd_alu_pkg::op_and: logic_res = op_a & op_b;
			simd_alu_pkg::op_or:  logic_res = op_a | op_b;
			simd_alu_pkg::op_xor: logic_res = op_a ^ op_b;
			simd_alu_pkg::op_not: logic_res = ~op_a;
			default:              logic_res = op_a;
		endcase
	end

	// final select
	always_comb begin
		case (cmd.op)
			simd_alu_pkg::op_and, simd_alu_pkg::op_or, simd_alu_pkg::op_xor,
			simd_alu_pkg::op_not, simd_alu_pkg::op_mov:
				result = logic_res;
			simd_alu_pkg::op_add, simd_alu_pkg::op_sub:
				result = sum;
			simd_alu_pkg::op_mul_even, simd_alu_pkg::op_mul_odd,
			simd_alu_pkg::op_sq_even, simd_alu_pkg::op_sq_odd:
				result = product;
			simd_alu_pkg::op_sll, simd_alu_pkg::op_srl, simd_alu_pkg::op_sra,
			simd_alu_pkg::op_rot_half:
				result = shifted;
			// nop and undefined opcodes
			default:
				result = '0;
		endcase
	end

endmodule

// File: hw/wb_alu_ctrl.sv
/* wishbone classic slave holding operand a, operand b, command and result
   result register reloads from the datapath one edge after each command write */
`timescale 1ns/1ns

module wb_alu_ctrl (
	input  logic                                  clk,
	input  logic                                  reset,
	input  simd_alu_pkg::wb_req_t                 wb_req,
	output simd_alu_pkg::wb_rsp_t                 wb_rsp,
	output logic [0:simd_alu_pkg::data_w-1]       op_a,
	output logic [0:simd_alu_pkg::data_w-1]       op_b,
	output simd_alu_pkg::alu_cmd_t                cmd,
	input  logic [0:simd_alu_pkg::data_w-1]       alu_result
);

	simd_alu_pkg::ctrl_state_e state;
	simd_alu_pkg::reg_addr_e   addr;

	// latched datapath output
	logic [0:simd_alu_pkg::data_w-1] result_q;
	// set by a command write, loads result_q on the next edge
	logic                            result_pend;
	// valid request from the master
	logic                            req;

	assign req  = wb_req.cyc && wb_req.stb;
	assign addr = simd_alu_pkg::reg_addr_e'(wb_req.adr);

	// idle/ack fsm and register writes
	always_ff @(posedge clk) begin
		if (reset) begin
			state       <= simd_alu_pkg::st_idle;
			op_a        <= '0;
			op_b        <= '0;
			cmd         <= '0;
			result_q    <= '0;
			result_pend <= 1'b0;
		end else begin
			// pending lasts exactly one cycle
			result_pend <= 1'b0;

			case (state)
				simd_alu_pkg::st_idle: begin
					// request seen here, ack in the next cycle
					if (req) begin
						state <= simd_alu_pkg::st_ack;
					end
				end
				simd_alu_pkg::st_ack: begin
					// one ack cycle only, no new request taken here
					state <= simd_alu_pkg::st_idle;
					// write lands on the edge that ends ack
					if (wb_req.we) begin
						case (addr)
							simd_alu_pkg::reg_a: begin
								op_a <= wb_req.dat_w;
							end
							simd_alu_pkg::reg_b: begin
								op_b <= wb_req.dat_w;
							end
							simd_alu_pkg::reg_cmd: begin
								// command is the low byte
								cmd         <= simd_alu_pkg::alu_cmd_t'(
									wb_req.dat_w[simd_alu_pkg::data_w-8 +: 8]);
								result_pend <= 1'b1;
							end
							default: begin
								// result register is read only
							end
						endcase
					end
				end
				default: begin
					state <= simd_alu_pkg::st_idle;
				end
			endcase

			// datapath has settled on the new command by now
			if (result_pend) begin
				result_q <= alu_result;
			end
		end
	end

	// ack and read-back mux
	always_comb begin
		wb_rsp.ack = (state == simd_alu_pkg::st_ack);
		case (addr)
			simd_alu_pkg::reg_a:   wb_rsp.dat_r = op_a;
			simd_alu_pkg::reg_b:   wb_rsp.dat_r = op_b;
			// command byte, zero extended
			simd_alu_pkg::reg_cmd: wb_rsp.dat_r = {{(simd_alu_pkg::data_w-8){1'b0}}, cmd};
			default:               wb_rsp.dat_r = result_q;
		endcase
	end

endmodule

// File: sim/alu_model.svh
/* reference model of the simd alu datapath, element 0 is the most significant
   included inside the testbench module, works on plain 64-bit vectors */
`ifndef ALU_MODEL_SVH
`define ALU_MODEL_SVH

// all ones over w bits
function automatic logic [63:0] elem_mask(int w);
	return (w >= 64) ? {64{1'b1}} : ((64'd1 << w) - 64'd1);
endfunction

// element e of x at w bits, counted from the top
function automatic logic [63:0] elem_get(logic [63:0] x, int w, int e);
	return (x >> (64 - (e + 1) * w)) & elem_mask(w);
endfunction

// x with element e replaced by v
function automatic logic [63:0] elem_put(logic [63:0] x, int w, int e, logic [63:0] v);
	int pos;
	pos = 64 - (e + 1) * w;
	return (x & ~(elem_mask(w) << pos)) | ((v & elem_mask(w)) << pos);
endfunction

// expected result for operands a, b and command {op, width}
function automatic logic [63:0] model_alu(logic [63:0] a, logic [63:0] b,
		logic [5:0] op, logic [1:0] wcode);
	int w;
	int n;
	int amt;
	logic odd;
	logic [63:0] m;
	logic [63:0] x;
	logic [63:0] y;
	logic [63:0] v;
	logic [63:0] r;
	w = 8 << wcode;
	n = 64 / w;
	m = elem_mask(w);
	odd = (op == 6'd9) || (op == 6'd17);
	r = '0;
	case (op)
		6'd1: r = a & b;
		6'd2: r = a | b;
		6'd3: r = a ^ b;
		6'd4: r = ~a;
		6'd5: r = a;
		// per element, wraps modulo the element size
		6'd6, 6'd7, 6'd10, 6'd11, 6'd12, 6'd13: begin
			for (int e = 0; e < n; e++) begin
				x = elem_get(a, w, e);
				y = elem_get(b, w, e);
				// low log2(w) bits of the b element
				amt = int'(y[5:0]) & (w - 1);
				case (op)
					6'd6:  v = x + y;
					6'd7:  v = x - y;
					6'd10: v = x << amt;
					6'd11: v = x >> amt;
					6'd12: begin
						v = x >> amt;
						// sign fill from the element top bit
						if (x[w - 1]) v = v | (m & ~(m >> amt));
					end
					default: v = (x << (w / 2)) | (x >> (w / 2));
				endcase
				r = elem_put(r, w, e, v);
			end
		end
		// even or odd elements, double width product, none at 64 bits
		6'd8, 6'd9, 6'd16, 6'd17: begin
			if (w < 64) begin
				for (int k = 0; k < n / 2; k++) begin
					x = elem_get(a, w, 2 * k + int'(odd));
					y = (op >= 6'd16) ? x : elem_get(b, w, 2 * k + int'(odd));
					r = elem_put(r, 2 * w, k, x * y);
				end
			end
		end
		// nop and unknown opcodes
		default: r = '0;
	endcase
	return r;
endfunction

`endif

// File: sim/tb_simd_alu.sv
/* testbench for the simd alu top, random operands written over wishbone
   every result read back is compared with the model in alu_model.svh */
`timescale 1ns/1ns

module tb_simd_alu;

	// inputs change this long after the rising edge
	localparam int stim_delay = 2;
	localparam int n_logic = 100;
	localparam int n_addsub = 200;
	// operand pairs per width
	localparam int n_mult = 25;
	localparam int n_shift = 25;
	localparam int n_unsup = 5;
	// bus accesses in the whole run
	localparam int n_access = 10 + n_logic * 12 + n_addsub * 6 + 16
		+ 4 * n_mult * 10 + 4 * n_shift * 10 + n_unsup * 14 + 8;
	// request, ack, then one idle cycle per access
	localparam int cycle_limit = n_access * 3 + 200;

	logic clk;
	logic reset;
	simd_alu_pkg::wb_req_t wb_req;
	simd_alu_pkg::wb_rsp_t wb_rsp;

	int seed = 17;
	int errors = 0;
	int checks = 0;
	int cycles = 0;
	// operands as last written to the dut
	logic [63:0] cur_a;
	logic [63:0] cur_b;
	logic [63:0] rd;
	logic [63:0] held;
	// multiply and square opcodes
	logic [5:0] mul_ops [0:3] = '{6'd8, 6'd9, 6'd16, 6'd17};
	// nop plus codes with no function
	logic [5:0] dead_ops [0:5] = '{6'd0, 6'd14, 6'd15, 6'd18, 6'd40, 6'd63};

	`include "alu_model.svh"

	simd_alu_top dut (
		.clk    (clk),
		.reset  (reset),
		.wb_req (wb_req),
		.wb_rsp (wb_rsp)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// watchdog
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= cycle_limit) begin
			$display("timeout: run still going after %0d cycles", cycles);
			$display("checks %0d, errors %0d", checks, errors + 1);
			$display("TB FAILED");
			$finish;
		end
	end

	task automatic compare_value(input string name, input logic [63:0] expected,
			input logic [63:0] actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("[FAIL] %0t ns %s expected %h actual %h", $time, name, expected, actual);
		end
	endtask

	function automatic logic [63:0] random_word();
		return {$random(seed), $random(seed)};
	endfunction

	// one classic cycle, ack due in the cycle after the request
	task automatic bus_access(input logic we, input logic [1:0] adr,
			input logic [63:0] wdata, output logic [63:0] rdata);
		int waited;
		waited = 0;
		rdata = '0;
		wb_req.cyc = 1'b1;
		wb_req.stb = 1'b1;
		wb_req.we = we;
		wb_req.adr = adr;
		wb_req.dat_w = wdata;
		do begin
			@(posedge clk);
			#stim_delay;
			waited++;
		end while (!wb_rsp.ack && waited < 8);
		if (!wb_rsp.ack) begin
			errors++;
			$display("%0t ns: no ack came for the access to register %0d", $time, adr);
		end else begin
			if (waited != 1) begin
				errors++;
				$display("%0t ns: ack came %0d cycles after the request", $time, waited);
			end
			rdata = wb_rsp.dat_r;
			@(posedge clk);
			#stim_delay;
			if (wb_rsp.ack) begin
				errors++;
				$display("%0t ns: ack stayed high for a second cycle", $time);
			end
		end
		// stb low for a full cycle before the next request
		wb_req = '0;
		@(posedge clk);
		#stim_delay;
	endtask

	task automatic wb_write(input logic [1:0] adr, input logic [63:0] data);
		logic [63:0] unused;
		bus_access(1'b1, adr, data, unused);
	endtask

	task automatic wb_read(input logic [1:0] adr, output logic [63:0] data);
		bus_access(1'b0, adr, '0, data);
	endtask

	task automatic load_operands(input logic [63:0] a, input logic [63:0] b);
		cur_a = a;
		cur_b = b;
		wb_write(simd_alu_pkg::reg_a, a);
		wb_write(simd_alu_pkg::reg_b, b);
	endtask

	// command write then result read, checked against the model
	task automatic run_cmd(input logic [5:0] op, input logic [1:0] width,
			output logic [63:0] res);
		wb_write(simd_alu_pkg::reg_cmd, {56'd0, op, width});
		wb_read(simd_alu_pkg::reg_result, res);
		compare_value($sformatf("result op %0d width %0d", op, width),
			model_alu(cur_a, cur_b, op, width), res);
	endtask

	initial begin
		wb_req = '0;
		reset = 1'b1;
		cur_a = '0;
		cur_b = '0;
		repeat (2) @(posedge clk);
		#stim_delay;
		reset = 1'b0;

		// reset values, then read back of a, b and command
		compare_value("ack", 64'd0, {63'd0, wb_rsp.ack});
		for (int r = 0; r < 4; r++) begin
			wb_read(2'(r), rd);
			compare_value($sformatf("register %0d after reset", r), 64'd0, rd);
		end
		cur_a = random_word();
		cur_b = random_word();
		// only the low byte is kept
		held = random_word();
		wb_write(simd_alu_pkg::reg_a, cur_a);
		wb_write(simd_alu_pkg::reg_b, cur_b);
		wb_write(simd_alu_pkg::reg_cmd, held);
		wb_read(simd_alu_pkg::reg_a, rd);
		compare_value("register a", cur_a, rd);
		wb_read(simd_alu_pkg::reg_b, rd);
		compare_value("register b", cur_b, rd);
		wb_read(simd_alu_pkg::reg_cmd, rd);
		compare_value("register cmd", {56'd0, held[7:0]}, rd);

		// logic and move at random widths
		for (int i = 0; i < n_logic; i++) begin
			load_operands(random_word(), random_word());
			for (int op = 1; op <= 5; op++) begin
				run_cmd(6'(op), 2'($random(seed)), rd);
			end
		end

		// add and subtract, widths in turn
		for (int i = 0; i < n_addsub; i++) begin
			load_operands(random_word(), random_word());
			run_cmd(6'd6, 2'(i), rd);
			run_cmd(6'd7, 2'(i), rd);
		end
		// all ones plus one, carry dies at the element top
		for (int w = 0; w < 4; w++) begin
			load_operands({64{1'b1}}, 64'd1);
			run_cmd(6'd6, 2'(w), rd);
			compare_value("carry stop", {64{1'b1}} << (8 << w), rd);
		end

		// multiply and square, w64 gives zero
		for (int w = 0; w < 4; w++) begin
			for (int i = 0; i < n_mult; i++) begin
				load_operands(random_word(), random_word());
				for (int k = 0; k < 4; k++) begin
					run_cmd(mul_ops[k], 2'(w), rd);
				end
			end
		end

		// sll, srl, sra, rot_half with random amounts per element
		for (int w = 0; w < 4; w++) begin
			for (int i = 0; i < n_shift; i++) begin
				load_operands(random_word(), random_word());
				for (int k = 0; k < 4; k++) begin
					run_cmd(6'(10 + k), 2'(w), rd);
				end
			end
		end

		// nop and unknown opcodes
		for (int i = 0; i < n_unsup; i++) begin
			load_operands(random_word(), random_word());
			for (int k = 0; k < 6; k++) begin
				run_cmd(dead_ops[k], 2'(i), rd);
			end
		end

		// new a alone leaves the result alone
		load_operands(random_word(), random_word());
		run_cmd(6'd6, 2'd1, rd);
		// add result on the operands the command saw
		held = model_alu(cur_a, cur_b, 6'd6, 2'd1);
		cur_a = random_word();
		wb_write(simd_alu_pkg::reg_a, cur_a);
		wb_read(simd_alu_pkg::reg_result, rd);
		compare_value("result after a write", held, rd);
		run_cmd(6'd6, 2'd1, rd);

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule
